// ==== common/dmem_macros.svh ====
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// Memory depth in 32-bit words.
`define DM_DEPTH_WORDS 1024

// Word address width, log2 of the depth.
`define DM_WORD_AW 10

// Wishbone byte address width.
`define WB_AW 32

`endif

// ==== common/dmem_pkg.sv ====
`include "dmem_macros.svh"

package dmem_pkg;

    // Access size as carried on the Wishbone address tag.
    typedef enum logic [1:0] {
        DM_BYTE = 2'b00,
        DM_HALF = 2'b01,
        DM_WORD = 2'b10
    } dm_size_t;

    // Tag of one access. Size plus the zero-extend flag for loads.
    typedef struct packed {
        logic     is_unsigned;
        dm_size_t size;
    } dm_op_t;

    // Aligned request towards the byte lanes.
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`DM_WORD_AW-1:0] addr;   // Word address.
        logic [1:0]             offset; // Byte offset in the word.
        dm_size_t               size;
        logic [31:0]            wdata;
    } dm_req_t;

    // What the extractor needs one cycle after acceptance.
    typedef struct packed {
        logic [1:0] offset;
        dm_size_t   size;
        logic       is_unsigned;
    } dm_load_t;

endpackage

// ==== common/wb_pkg.sv ====
`include "dmem_macros.svh"

package wb_pkg;

    // Master to slave, Wishbone classic.
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [`WB_AW-1:0] adr;
        logic [31:0]       dat;
        dmem_pkg::dm_op_t  tga;    // Size and signedness of the access.
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== dmem/store_aligner.sv ====
`timescale 1ns/1ps

module store_aligner (
    input  dmem_pkg::dm_req_t req,
    output logic [3:0]        lane_we,
    output logic [3:0][7:0]   lane_wdata
);
    import dmem_pkg::*;

    logic       do_write;
    logic [3:0] size_mask;

    assign do_write = req.valid && req.we;

    // Replicate the low part so every candidate lane sees its byte.
    always_comb begin
        case (req.size)
            DM_BYTE: lane_wdata = {4{req.wdata[7:0]}};
            DM_HALF: lane_wdata = {2{req.wdata[15:0]}};
            default: lane_wdata = req.wdata;
        endcase
    end

    // Lanes touched by the access, before the offset shift.
    always_comb begin
        case (req.size)
            DM_BYTE: size_mask = 4'b0001;
            DM_HALF: size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        if (do_write) begin
            lane_we = size_mask << req.offset;
        end else begin
            lane_we = 4'b0000;
        end
    end

endmodule

// ==== dmem/byte_lane_ram.sv ====
`timescale 1ns/1ps
`include "dmem_macros.svh"

module byte_lane_ram (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`DM_WORD_AW-1:0] addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    logic [7:0] mem [`DM_DEPTH_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // Old contents on a same-cycle write.
    end

endmodule

// ==== dmem/load_extractor.sv ====
`timescale 1ns/1ps

module load_extractor (
    input  dmem_pkg::dm_load_t ctx,
    input  logic [3:0][7:0]    lane_rdata,
    output logic [31:0]        data
);
    import dmem_pkg::*;

    logic [31:0] shifted;
    logic        sign_bit;

    // Bring the addressed lane down to bit 0.
    assign shifted = lane_rdata >> {ctx.offset, 3'b000};

    always_comb begin
        case (ctx.size)
            DM_BYTE: begin
                sign_bit = shifted[7] && !ctx.is_unsigned;
                data     = {{24{sign_bit}}, shifted[7:0]};
            end
            DM_HALF: begin
                sign_bit = shifted[15] && !ctx.is_unsigned;
                data     = {{16{sign_bit}}, shifted[15:0]};
            end
            default: begin
                sign_bit = 1'b0;
                data     = lane_rdata; // Word passes through.
            end
        endcase
    end

endmodule

// ==== dmem/dmem_core.sv ====
`timescale 1ns/1ps

module dmem_core (
    input  logic               clk,
    input  dmem_pkg::dm_req_t  req,
    input  dmem_pkg::dm_load_t load_ctx,
    output logic [31:0]        load_data
);

    logic [3:0]      lane_we;
    logic [3:0][7:0] lane_wdata;
    logic [3:0][7:0] lane_rdata;

    store_aligner store_aligner_i (
        .req        (req),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata)
    );

    // Lane i holds byte i of every word, little-endian.
    for (genvar i = 0; i < 4; i++) begin : g_lane
        byte_lane_ram lane_ram_i (
            .clk   (clk),
            .we    (lane_we[i]),
            .addr  (req.addr),
            .wdata (lane_wdata[i]),
            .rdata (lane_rdata[i])
        );
    end

    load_extractor load_extractor_i (
        .ctx        (load_ctx),
        .lane_rdata (lane_rdata),
        .data       (load_data)
    );

endmodule

// ==== rtl/wb_dmem_slave.sv ====
`timescale 1ns/1ps
`include "dmem_macros.svh"

module wb_dmem_slave (
    input  logic               clk,
    input  logic               reset,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    output dmem_pkg::dm_req_t  mem_req,
    output dmem_pkg::dm_load_t load_ctx,
    input  logic [31:0]        load_data
);
    import dmem_pkg::*;

    logic     accept;
    logic     aligned;
    logic     ack_q;
    logic     err_q;
    logic     rd_q;
    dm_load_t ctx_q;

    // A pending response blocks the held request, so one request gets one answer.
    assign accept = wb_req.cyc && wb_req.stb && !ack_q && !err_q;

    always_comb begin
        case (wb_req.tga.size)
            DM_BYTE: aligned = 1'b1;
            DM_HALF: aligned = !wb_req.adr[0];
            DM_WORD: aligned = (wb_req.adr[1:0] == 2'b00);
            default: aligned = 1'b0; // Reserved size code is answered with err.
        endcase
    end

    // Misaligned requests never reach the lanes.
    always_comb begin
        mem_req.valid  = accept && aligned;
        mem_req.we     = wb_req.we;
        mem_req.addr   = wb_req.adr[`DM_WORD_AW+1:2];
        mem_req.offset = wb_req.adr[1:0];
        mem_req.size   = wb_req.tga.size;
        mem_req.wdata  = wb_req.dat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            rd_q  <= 1'b0;
        end else begin
            ack_q <= accept && aligned;
            err_q <= accept && !aligned;
            rd_q  <= accept && aligned && !wb_req.we;
        end
    end

    // Load context lines up with the registered lane outputs.
    always_ff @(posedge clk) begin
        if (accept) begin
            ctx_q.offset      <= wb_req.adr[1:0];
            ctx_q.size        <= wb_req.tga.size;
            ctx_q.is_unsigned <= wb_req.tga.is_unsigned;
        end
    end

    assign load_ctx = ctx_q;

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.err = err_q;
        wb_rsp.dat = rd_q ? load_data : 32'h0; // Zero unless a read is acknowledged.
    end

endmodule

// ==== rtl/dmem_top.sv ====
`timescale 1ns/1ps

module dmem_top (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    dmem_pkg::dm_req_t  mem_req;
    dmem_pkg::dm_load_t load_ctx;
    logic [31:0]        load_data;

    wb_dmem_slave wb_dmem_slave_i (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .mem_req   (mem_req),
        .load_ctx  (load_ctx),
        .load_data (load_data)
    );

    dmem_core dmem_core_i (
        .clk       (clk),
        .req       (mem_req),
        .load_ctx  (load_ctx),
        .load_data (load_data)
    );

endmodule

// ==== verif/dmem_chk.sv ====
`timescale 1ns/1ps

module dmem_chk (
    input logic            clk,
    input logic            reset,
    input wb_pkg::wb_req_t wb_req,
    input wb_pkg::wb_rsp_t wb_rsp
);

    logic accepted;

    // Same acceptance rule as the slave, seen from the bus.
    assign accepted = wb_req.cyc && wb_req.stb && !wb_rsp.ack && !wb_rsp.err;

    ack_err_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(wb_rsp.ack && wb_rsp.err))
        else $error("ack and err are high together");

    response_after_accept: assert property (@(posedge clk) disable iff (reset)
        (wb_rsp.ack || wb_rsp.err) |-> $past(accepted))
        else $error("ack or err without an accepted request one cycle before");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!wb_rsp.ack && !wb_rsp.err))
        else $error("ack or err high after a reset cycle");

endmodule

bind wb_dmem_slave dmem_chk dmem_chk_i (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

// ==== verif/dmem_tb.sv ====
`timescale 1ns/1ps
`include "dmem_macros.svh"

module dmem_tb;
    import dmem_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int ACK_TIMEOUT = 20;
    localparam int MEM_BYTES   = `DM_DEPTH_WORDS * 4;
    localparam int RAND_BASE   = 32'h200; // Window used by the random accesses.
    localparam int RAND_WORDS  = 16;
    localparam int RAND_COUNT  = 200;

    logic            clk;
    logic            reset;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_rsp_t wb_rsp;

    logic [7:0]  model [MEM_BYTES]; // Little-endian byte image of the memory.
    logic [31:0] lcg_state;
    int          check_errors;
    int          timeouts;

    dmem_top dut_i (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void model_store(logic [31:0] adr, logic [31:0] dat, dm_size_t size);
        model[adr] = dat[7:0];
        if (size != DM_BYTE) begin
            model[adr + 1] = dat[15:8];
        end
        if (size == DM_WORD) begin
            model[adr + 2] = dat[23:16];
            model[adr + 3] = dat[31:24];
        end
    endfunction

    function automatic logic [31:0] model_load(logic [31:0] adr, dm_size_t size, logic uns);
        logic [31:0] val;
        case (size)
            DM_BYTE: val = {{24{model[adr][7] && !uns}}, model[adr]};
            DM_HALF: val = {{16{model[adr + 1][7] && !uns}}, model[adr + 1], model[adr]};
            default: val = {model[adr + 3], model[adr + 2], model[adr + 1], model[adr]};
        endcase
        return val;
    endfunction

    // One classic cycle. Starts and ends 2 ns after a rising edge.
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input dm_size_t size, input logic uns,
                             output logic ack, output logic err, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        ack    = 1'b0;
        err    = 1'b0;
        rdata  = 32'h0;
        wb_req.cyc             = 1'b1;
        wb_req.stb             = 1'b1;
        wb_req.we              = we;
        wb_req.adr             = adr;
        wb_req.dat             = dat;
        wb_req.tga.size        = size;
        wb_req.tga.is_unsigned = uns;
        while (!ack && !err && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            ack   = wb_rsp.ack;
            err   = wb_rsp.err;
            rdata = wb_rsp.dat;
            cycles++;
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        if (!ack && !err) begin
            $display("Timeout at %0t: no ack or err for address 0x%08h after %0d cycles",
                     $time, adr, ACK_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input dm_size_t size,
                            output logic ack, output logic err);
        logic [31:0] rdata;
        bus_cycle(1'b1, adr, dat, size, 1'b0, ack, err, rdata);
        if (ack) begin
            check_value(rdata, 32'h0, $sformatf("data on write ack from 0x%08h", adr));
        end
    endtask

    task automatic wb_read(input logic [31:0] adr, input dm_size_t size, input logic uns,
                           output logic ack, output logic err, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, size, uns, ack, err, data);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s gave 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_response(input logic ack, input logic err, input logic exp_err,
                                  input string what);
        if (ack || err) begin
            if (ack !== ~exp_err || err !== exp_err) begin
                $display("CHECK FAILED at %0t: %s got ack=%0b err=%0b, expected ack=%0b err=%0b",
                         $time, what, ack, err, ~exp_err, exp_err);
                check_errors++;
            end
        end
    endtask

    task automatic store(input logic [31:0] adr, input logic [31:0] dat, input dm_size_t size);
        logic ack;
        logic err;
        wb_write(adr, dat, size, ack, err);
        check_response(ack, err, 1'b0, $sformatf("store to 0x%08h", adr));
        if (ack) begin
            model_store(adr, dat, size);
        end
    endtask

    task automatic load_check(input logic [31:0] adr, input dm_size_t size, input logic uns);
        logic        ack;
        logic        err;
        logic [31:0] data;
        wb_read(adr, size, uns, ack, err, data);
        check_response(ack, err, 1'b0, $sformatf("load from 0x%08h", adr));
        if (ack) begin
            check_value(data, model_load(adr, size, uns),
                        $sformatf("%s load from 0x%08h", size.name(), adr));
        end
    endtask

    task automatic misaligned_access(input logic we, input logic [31:0] adr, input dm_size_t size);
        logic        ack;
        logic        err;
        logic [31:0] data;
        bus_cycle(we, adr, 32'hDEAD_BEEF, size, 1'b0, ack, err, data);
        check_response(ack, err, 1'b1, $sformatf("misaligned %s at 0x%08h", size.name(), adr));
        if (err && !we) begin
            check_value(data, 32'h0, "read data on err");
        end
    endtask

    task automatic test_word_rw();
        logic [31:0] addrs [4];
        addrs = '{32'h0, 32'h4, 32'h100, 32'hFFC}; // Last one is the top word.
        foreach (addrs[i]) begin
            store(addrs[i], {addrs[i][15:0] ^ 16'h5A5A, ~addrs[i][15:0]}, DM_WORD);
        end
        foreach (addrs[i]) begin
            load_check(addrs[i], DM_WORD, 1'b0);
        end
    endtask

    task automatic test_byte_merge();
        logic        ack;
        logic        err;
        logic [31:0] data;
        store(32'h40, 32'h0000_0011, DM_BYTE);
        store(32'h41, 32'hFFFF_FF22, DM_BYTE); // Upper data bits must be ignored.
        store(32'h42, 32'h0000_0033, DM_BYTE);
        store(32'h43, 32'hABCD_EF44, DM_BYTE);
        wb_read(32'h40, DM_WORD, 1'b0, ack, err, data);
        check_response(ack, err, 1'b0, "merged word load");
        check_value(data, 32'h4433_2211, "merged word load");
        store(32'h42, 32'h1234_BEEF, DM_HALF);
        wb_read(32'h40, DM_WORD, 1'b0, ack, err, data);
        check_response(ack, err, 1'b0, "word load after halfword store");
        check_value(data, 32'hBEEF_2211, "word load after halfword store");
    endtask

    task automatic test_extend();
        store(32'h80, 32'hF08A_9CB7, DM_WORD); // Top bit set in every byte and half.
        for (int off = 0; off < 4; off++) begin
            load_check(32'h80 + off, DM_BYTE, 1'b0);
            load_check(32'h80 + off, DM_BYTE, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_check(32'h80 + off, DM_HALF, 1'b0);
            load_check(32'h80 + off, DM_HALF, 1'b1);
        end
    endtask

    task automatic test_misaligned();
        store(32'hC0, 32'h1234_5678, DM_WORD);
        for (int off = 1; off < 4; off++) begin
            misaligned_access(1'b1, 32'hC0 + off, DM_WORD);
            misaligned_access(1'b0, 32'hC0 + off, DM_WORD);
        end
        for (int off = 1; off < 4; off += 2) begin
            misaligned_access(1'b1, 32'hC0 + off, DM_HALF);
            misaligned_access(1'b0, 32'hC0 + off, DM_HALF);
        end
        load_check(32'hC0, DM_WORD, 1'b0);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] adr;
        dm_size_t    size;
        for (int w = 0; w < RAND_WORDS; w++) begin
            store(RAND_BASE + 4 * w, lcg_next(), DM_WORD); // Keep every load defined.
        end
        for (int n = 0; n < RAND_COUNT; n++) begin
            r    = lcg_next();
            size = dm_size_t'(r[31:16] % 3);
            adr  = RAND_BASE + ((lcg_next() >> 16) % (RAND_WORDS * 4));
            if (size == DM_HALF) begin
                adr[0] = 1'b0;
            end else if (size == DM_WORD) begin
                adr[1:0] = 2'b00;
            end
            if (r[20]) begin
                store(adr, lcg_next(), size);
            end else begin
                load_check(adr, size, r[21]);
            end
        end
    endtask

    initial begin
        wb_req       = '0;
        reset        = 1'b1;
        lcg_state    = 32'd17;
        check_errors = 0;
        timeouts     = 0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_word_rw();
        test_byte_merge();
        test_extend();
        test_misaligned();
        test_random();

        $display("Summary: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/dmem_pkg.sv
common/wb_pkg.sv
dmem/store_aligner.sv
dmem/byte_lane_ram.sv
dmem/load_extractor.sv
dmem/dmem_core.sv
rtl/wb_dmem_slave.sv
rtl/dmem_top.sv
verif/dmem_chk.sv
verif/dmem_tb.sv

// ==== Bender.yml ====
package:
  name: wb_dmem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dmem_pkg.sv
      - common/wb_pkg.sv
      - dmem/store_aligner.sv
      - dmem/byte_lane_ram.sv
      - dmem/load_extractor.sv
      - dmem/dmem_core.sv
      - rtl/wb_dmem_slave.sv
      - rtl/dmem_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/dmem_chk.sv
      - verif/dmem_tb.sv
